//--- common/fetch_pkg.sv
package fetch_pkg;

    // scalar widths with a meaning in the front end
    typedef logic [31:0] addr_t;    // byte address of an instruction
    typedef logic [31:0] inst_t;    // one instruction word
    typedef logic [4:0]  qcount_t;  // queue occupancy, holds 0..16

    // what the queue presents to decode each cycle
    typedef struct packed {
        addr_t addr1;          // master slot
        inst_t inst1;
        addr_t addr2;          // slave slot
        inst_t inst2;
        logic  in_delay_slot;  // master is a held delay-slot word
    } issue_pair_t;

    // branch correction from the consumer
    typedef struct packed {
        addr_t target;
        logic  keep_slot;      // branch went alone in the master slot
        addr_t slot_pc;        // its delay slot
    } redirect_t;

    // issue statistics
    typedef struct packed {
        logic [31:0] master_cnt;
        logic [31:0] slave_cnt;
    } perf_t;

    typedef enum logic [1:0] {
        FS_IDLE,   // waiting for start
        FS_RUN,    // walking pc
        FS_SLOT    // fetching a missing delay slot word
    } fetch_state_t;

endpackage

//--- common/mem_pkg.sv
package mem_pkg;

    typedef logic [63:0] line_t;     // two words, lower word at lower address
    typedef logic [9:0]  line_idx_t; // line index into the memory

    typedef struct packed {
        logic      en;
        logic      we;
        line_idx_t line_addr;
        line_t     wdata;
    } mem_req_t;

    // owner of the memory port in the current cycle
    typedef enum logic [1:0] {
        GRANT_NONE,
        GRANT_LOADER,
        GRANT_FETCH
    } grant_t;

endpackage

//--- inst_fifo/inst_fifo.sv
`timescale 1ns/1ps

module inst_fifo
    import fetch_pkg::*;
#(
    parameter int DEPTH_LOG2 = 4
) (
    input  logic        clk,
    input  logic        fifo_rst,
    input  logic        flush,         // branch redirect, drop everything
    input  logic        delay_flush,   // keep the delay slot of that branch
    input  logic        read_en1,      // master issues
    input  logic        read_en2,      // slave issues
    input  logic        write_en1,
    input  logic        write_en2,
    input  addr_t       write_address1,
    input  addr_t       write_address2,
    input  inst_t       write_data1,
    input  inst_t       write_data2,
    output issue_pair_t issue,
    output logic        empty,
    output logic        almost_empty,
    output logic        full,
    output logic        slot_pending,  // slot word still to come from fetch
    output perf_t       perf
);

    localparam int      DEPTH      = 1 << DEPTH_LOG2;
    localparam qcount_t FULL_LEVEL = qcount_t'(DEPTH - 2); // no room for a whole line

    addr_t addr_q [DEPTH];
    inst_t inst_q [DEPTH];

    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic [DEPTH_LOG2-1:0] wr_nxt;
    logic [DEPTH_LOG2-1:0] rd_nxt;
    qcount_t count;
    qcount_t wr_num;
    qcount_t rd_num;

    // delay slot register
    logic  slot_valid;
    logic  slot_held;
    addr_t slot_addr;
    inst_t slot_inst;

    logic ring_we1;
    logic ring_we2;
    logic rd_fire1;
    logic rd_fire2;
    logic two_avail;
    logic master_fire;

    assign wr_nxt    = wr_ptr + 1'b1;
    assign rd_nxt    = rd_ptr + 1'b1;
    assign two_avail = count >= qcount_t'(2);
    assign slot_held = slot_valid && !slot_pending; // slot word present, overrides queue

    assign empty        = (count == '0) && !slot_held;
    assign almost_empty = (count == qcount_t'(1));
    assign full         = count >= FULL_LEVEL;

    // a word filling the pending slot does not also enter the ring
    assign ring_we1 = write_en1 && !slot_pending;
    assign ring_we2 = write_en2 && !slot_pending;

    assign rd_fire1    = read_en1 && !slot_valid && (count != '0);
    assign rd_fire2    = rd_fire1 && read_en2 && two_avail;
    assign master_fire = read_en1 && !empty;

    assign wr_num = qcount_t'(ring_we1) + qcount_t'(ring_we2);
    assign rd_num = qcount_t'(rd_fire1) + qcount_t'(rd_fire2);

    always_comb begin
        issue = '0;
        if (slot_held) begin
            issue.addr1         = slot_addr;
            issue.inst1         = slot_inst;
            issue.in_delay_slot = 1'b1;
        end else if (count != '0) begin
            issue.addr1 = addr_q[rd_ptr];
            issue.inst1 = inst_q[rd_ptr];
            if (two_avail) begin // slave only when a second entry exists
                issue.addr2 = addr_q[rd_nxt];
                issue.inst2 = inst_q[rd_nxt];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ring_we1) begin
            addr_q[wr_ptr] <= write_address1;
            inst_q[wr_ptr] <= write_data1;
        end
        if (ring_we2) begin
            addr_q[wr_nxt] <= write_address2;
            inst_q[wr_nxt] <= write_data2;
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (ring_we1) begin
                wr_ptr <= ring_we2 ? wr_ptr + 2'd2 : wr_nxt;
            end
            if (rd_fire1) begin
                rd_ptr <= rd_fire2 ? rd_ptr + 2'd2 : rd_nxt;
            end
            count <= count + wr_num - rd_num;
        end
    end

    // slot control
    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            slot_valid   <= 1'b0;
            slot_pending <= 1'b0;
        end else if (flush) begin
            slot_valid   <= delay_flush;
            // neither in the ring nor arriving right now
            slot_pending <= delay_flush && !two_avail && !write_en1;
        end else if (slot_pending && write_en1) begin
            slot_pending <= 1'b0;
        end else if (slot_held && read_en1) begin
            slot_valid <= 1'b0;          // master took the slot
        end
    end

    always_ff @(posedge clk) begin
        if (flush && delay_flush) begin
            // branch sits at rd_ptr, its slot right behind it
            if (two_avail) begin
                slot_addr <= addr_q[rd_nxt];
                slot_inst <= inst_q[rd_nxt];
            end else begin
                slot_addr <= write_address1;
                slot_inst <= write_data1;
            end
        end else if (slot_pending && write_en1) begin
            slot_addr <= write_address1;
            slot_inst <= write_data1;
        end
    end

    // issue counters
    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            perf <= '0;
        end else begin
            if (master_fire) begin
                perf.master_cnt <= perf.master_cnt + 32'd1;
            end
            if (rd_fire2) begin
                perf.slave_cnt <= perf.slave_cnt + 32'd1;
            end
        end
    end

    // fetch stops at the full level, so a line in flight always fits
    a_count_bound: assert property (
        @(posedge clk) disable iff (fifo_rst) count <= qcount_t'(DEPTH));

    // fetch unit writes the lower slot first
    a_write_order: assert property (
        @(posedge clk) disable iff (fifo_rst) write_en2 |-> write_en1);

endmodule

//--- hdl/imem_arbiter.sv
`timescale 1ns/1ps

module imem_arbiter
    import mem_pkg::*;
(
    input  mem_req_t load_req,
    input  mem_req_t fetch_req,
    output mem_req_t mem_req,
    output logic     fetch_gnt,
    output grant_t   grant
);

    // loader always wins and fetch just holds its request
    always_comb begin
        mem_req   = '0;
        fetch_gnt = 1'b0;
        grant     = GRANT_NONE;
        if (load_req.en) begin
            mem_req = load_req;
            grant   = GRANT_LOADER;
        end else if (fetch_req.en) begin
            mem_req   = fetch_req;
            fetch_gnt = 1'b1;
            grant     = GRANT_FETCH;
        end
    end

    // each requester has a fixed direction on the port
    always_comb begin
        if (load_req.en) begin
            a_loader_write: assert (load_req.we);
        end
        if (fetch_req.en) begin
            a_fetch_read: assert (!fetch_req.we);
        end
    end

endmodule

//--- hdl/inst_mem.sv
`timescale 1ns/1ps

module inst_mem
    import mem_pkg::*;
#(
    parameter int LINES = 1024
) (
    input  logic     clk,
    input  mem_req_t mem_req,
    output line_t    rdata
);

    line_t mem [LINES];

    // single port, so a write cycle returns no data
    always_ff @(posedge clk) begin
        if (mem_req.en) begin
            if (mem_req.we) begin
                mem[mem_req.line_addr] <= mem_req.wdata;
            end else begin
                rdata <= mem[mem_req.line_addr]; // valid one cycle later
            end
        end
    end

endmodule

//--- hdl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
    import fetch_pkg::*;
    import mem_pkg::*;
#(
    parameter addr_t RESET_PC = '0
) (
    input  logic      clk,
    input  logic      fifo_rst,
    input  logic      start,
    input  logic      redirect_valid,
    input  redirect_t redir,
    input  logic      fetch_gnt,
    input  logic      full,
    input  logic      slot_pending,
    input  line_t     rdata,
    output mem_req_t  fetch_req,
    output logic      write_en1,
    output logic      write_en2,
    output addr_t     write_address1,
    output addr_t     write_address2,
    output inst_t     write_data1,
    output inst_t     write_data2
);

    fetch_state_t state;
    addr_t        pc;
    addr_t        slot_addr;    // delay slot to fetch before the target
    addr_t        cur_addr;
    logic         resp_pending; // read granted last cycle
    logic         stale;        // that read predates a redirect
    logic         req_fire;
    logic         resp_ok;

    assign cur_addr = (state == FS_SLOT) ? slot_addr : pc;
    assign req_fire = fetch_req.en && fetch_gnt;
    assign resp_ok  = resp_pending && !stale;

    always_comb begin
        fetch_req           = '0;
        fetch_req.line_addr = cur_addr[12:3];
        case (state)
            FS_RUN:  fetch_req.en = !full && !resp_pending && !slot_pending;
            FS_SLOT: fetch_req.en = !resp_pending;
            default: fetch_req.en = 1'b0;
        endcase
    end

    // odd word pc or slot fetch: only the upper word, through port 1
    assign write_en1      = resp_ok;
    assign write_en2      = resp_ok && (state == FS_RUN) && !cur_addr[2];
    assign write_address1 = cur_addr;
    assign write_address2 = cur_addr + 32'd4;
    assign write_data1    = cur_addr[2] ? rdata[63:32] : rdata[31:0];
    assign write_data2    = rdata[63:32];

    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            state        <= FS_IDLE;
            pc           <= RESET_PC;
            slot_addr    <= '0;
            resp_pending <= 1'b0;
            stale        <= 1'b0;
        end else begin
            resp_pending <= req_fire;                   // memory answers next cycle
            stale        <= redirect_valid && req_fire; // wrong path read
            if (redirect_valid && state != FS_IDLE) begin
                state <= FS_RUN;
                pc    <= redir.target;
                if (redir.keep_slot) begin
                    slot_addr <= redir.slot_pc;
                end
            end else begin
                case (state)
                    FS_IDLE: if (start) state <= FS_RUN;
                    FS_RUN: begin
                        if (slot_pending) begin
                            state <= FS_SLOT;  // queue could not find the slot word
                        end else if (resp_ok) begin
                            pc <= {pc[31:3] + 29'd1, 3'b000}; // next line
                        end
                    end
                    FS_SLOT: if (resp_ok) state <= FS_RUN; // back to target
                    default: state <= FS_IDLE;
                endcase
            end
        end
    end

endmodule

//--- hdl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
    import mem_pkg::*;
#(
    parameter int    DEPTH_LOG2 = 4,
    parameter int    LINES      = 1024,
    parameter addr_t RESET_PC   = '0
) (
    input  logic        clk,
    input  logic        fifo_rst,
    input  logic        start,
    input  mem_req_t    load_req,
    input  logic        read_en1,
    input  logic        read_en2,
    input  logic        redirect_valid,
    input  redirect_t   redir,
    output issue_pair_t issue,
    output logic        empty,
    output logic        almost_empty,
    output logic        full,
    output perf_t       perf
);

    mem_req_t fetch_req;
    mem_req_t mem_req;
    logic     fetch_gnt;
    grant_t   grant;
    line_t    rdata;
    logic     write_en1;
    logic     write_en2;
    addr_t    write_address1;
    addr_t    write_address2;
    inst_t    write_data1;
    inst_t    write_data2;
    logic     slot_pending;
    logic     flush;
    logic     delay_flush;

    assign flush       = redirect_valid;
    assign delay_flush = redirect_valid && redir.keep_slot;

    imem_arbiter u_arbiter (
        .load_req  (load_req),
        .fetch_req (fetch_req),
        .mem_req   (mem_req),
        .fetch_gnt (fetch_gnt),
        .grant     (grant)
    );

    inst_mem #(
        .LINES (LINES)
    ) u_mem (
        .clk     (clk),
        .mem_req (mem_req),
        .rdata   (rdata)
    );

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk            (clk),
        .fifo_rst       (fifo_rst),
        .start          (start),
        .redirect_valid (redirect_valid),
        .redir          (redir),
        .fetch_gnt      (fetch_gnt),
        .full           (full),
        .slot_pending   (slot_pending),
        .rdata          (rdata),
        .fetch_req      (fetch_req),
        .write_en1      (write_en1),
        .write_en2      (write_en2),
        .write_address1 (write_address1),
        .write_address2 (write_address2),
        .write_data1    (write_data1),
        .write_data2    (write_data2)
    );

    inst_fifo #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) u_fifo (
        .clk            (clk),
        .fifo_rst       (fifo_rst),
        .flush          (flush),
        .delay_flush    (delay_flush),
        .read_en1       (read_en1),
        .read_en2       (read_en2),
        .write_en1      (write_en1),
        .write_en2      (write_en2),
        .write_address1 (write_address1),
        .write_address2 (write_address2),
        .write_data1    (write_data1),
        .write_data2    (write_data2),
        .issue          (issue),
        .empty          (empty),
        .almost_empty   (almost_empty),
        .full           (full),
        .slot_pending   (slot_pending),
        .perf           (perf)
    );

    // one line in flight at a time, so fetch never owns the port twice in a row
    a_fetch_spacing: assert property (
        @(posedge clk) disable iff (fifo_rst)
        grant == GRANT_FETCH |=> grant != GRANT_FETCH);

endmodule

//--- verification/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch
    import fetch_pkg::*;
    import mem_pkg::*;
();

    localparam int    CLK_PERIOD    = 8;
    localparam int    LOAD_LINES    = 1024;
    localparam int    RANDOM_CYCLES = 700;
    localparam int    CYCLE_BUDGET  = 3 + LOAD_LINES + 2 * RANDOM_CYCLES + 600;
    localparam addr_t RESET_PC      = 32'h0;
    localparam inst_t INST_KEY      = 32'hC3A5_0000; // nonzero for every loaded address

    logic        clk;
    logic        fifo_rst;
    logic        start;
    mem_req_t    load_req;
    logic        read_en1;
    logic        read_en2;
    logic        redirect_valid;
    redirect_t   redir;
    issue_pair_t issue;
    logic        empty;
    logic        almost_empty;
    logic        full;
    perf_t       perf;
    logic        slave_valid;

    // reference model of the issue stream
    addr_t       exp_pc;
    addr_t       exp_nxt;
    addr_t       after_pc;    // target to resume at after a delay slot
    addr_t       after_nxt;
    logic        expect_slot;
    logic        slot_nxt;
    logic [31:0] m_cnt;
    logic [31:0] m_nxt;
    logic [31:0] s_cnt;
    logic [31:0] s_nxt;
    logic        keep_seen;
    int          buf_cnt;
    int          pend_cnt;
    integer      seed = 34469;

    fetch_top #(
        .DEPTH_LOG2 (4),
        .LINES      (LOAD_LINES),
        .RESET_PC   (RESET_PC)
    ) DUT (
        .clk            (clk),
        .fifo_rst       (fifo_rst),
        .start          (start),
        .load_req       (load_req),
        .read_en1       (read_en1),
        .read_en2       (read_en2),
        .redirect_valid (redirect_valid),
        .redir          (redir),
        .issue          (issue),
        .empty          (empty),
        .almost_empty   (almost_empty),
        .full           (full),
        .perf           (perf)
    );

    assign slave_valid = !empty && !almost_empty && !issue.in_delay_slot;

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task report_value(input string name, input logic [128:0] expv, input logic [128:0] actv);
        $display("ERR t=%0t %s expected %0h actual %0h", $time, name, expv, actv);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task fail_now(input string what);
        $display("%0t: %s", $time, what);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    function automatic mem_req_t line_write(input int idx);
        mem_req_t req;
        addr_t    base;
        base          = addr_t'(idx) << 3;
        req           = '0;
        req.en        = 1'b1;
        req.we        = 1'b1;
        req.line_addr = line_idx_t'(idx);
        req.wdata     = {(base + 32'd4) ^ INST_KEY, base ^ INST_KEY};
        return req;
    endfunction

    // next expectation worked out between edges
    always @(negedge clk) begin
        exp_nxt   = exp_pc;
        after_nxt = after_pc;
        slot_nxt  = expect_slot;
        m_nxt     = m_cnt;
        s_nxt     = s_cnt;
        if (read_en1 && !empty) begin
            m_nxt = m_cnt + 1;
            if (issue.in_delay_slot) begin
                exp_nxt  = after_pc;
                slot_nxt = 1'b0;
            end else if (read_en2 && slave_valid) begin
                s_nxt   = s_cnt + 1;
                exp_nxt = exp_pc + 32'd8;
            end else begin
                exp_nxt = exp_pc + 32'd4;
            end
        end
        if (redirect_valid) begin
            exp_nxt   = redir.keep_slot ? redir.slot_pc : redir.target;
            slot_nxt  = redir.keep_slot;
            after_nxt = redir.target;
        end
        if (keep_seen) begin
            if (DUT.slot_pending) pend_cnt++;
            else buf_cnt++;
        end
        keep_seen = redirect_valid && redir.keep_slot;
    end

    always @(posedge clk) begin
        if (fifo_rst) begin
            exp_pc      <= RESET_PC;
            after_pc    <= RESET_PC;
            expect_slot <= 1'b0;
            m_cnt       <= '0;
            s_cnt       <= '0;
        end else begin
            exp_pc      <= exp_nxt;
            after_pc    <= after_nxt;
            expect_slot <= slot_nxt;
            m_cnt       <= m_nxt;
            s_cnt       <= s_nxt;
        end
    end

    a_master_addr: assert property (@(posedge clk) disable iff (fifo_rst)
        !empty |-> issue.addr1 == exp_pc)
        else report_value("issue.addr1", $sampled(exp_pc), $sampled(issue.addr1));
    a_master_inst: assert property (@(posedge clk) disable iff (fifo_rst)
        !empty |-> issue.inst1 == (issue.addr1 ^ INST_KEY))
        else report_value("issue.inst1", $sampled(issue.addr1 ^ INST_KEY), $sampled(issue.inst1));
    a_slave_addr: assert property (@(posedge clk) disable iff (fifo_rst)
        slave_valid |-> issue.addr2 == issue.addr1 + 32'd4)
        else report_value("issue.addr2", $sampled(issue.addr1 + 32'd4), $sampled(issue.addr2));
    a_slave_inst: assert property (@(posedge clk) disable iff (fifo_rst)
        slave_valid |-> issue.inst2 == (issue.addr2 ^ INST_KEY))
        else report_value("issue.inst2", $sampled(issue.addr2 ^ INST_KEY), $sampled(issue.inst2));
    a_slot_flag: assert property (@(posedge clk) disable iff (fifo_rst)
        !empty |-> issue.in_delay_slot == expect_slot)
        else report_value("issue.in_delay_slot", $sampled(expect_slot),
                          $sampled(issue.in_delay_slot));
    a_empty_zero: assert property (@(posedge clk) disable iff (fifo_rst)
        empty |-> issue == '0)
        else report_value("issue", '0, $sampled(issue));
    a_almost_addr: assert property (@(posedge clk) disable iff (fifo_rst)
        almost_empty && !issue.in_delay_slot |-> issue.addr2 == '0)
        else report_value("issue.addr2", '0, $sampled(issue.addr2));
    a_almost_inst: assert property (@(posedge clk) disable iff (fifo_rst)
        almost_empty && !issue.in_delay_slot |-> issue.inst2 == '0)
        else report_value("issue.inst2", '0, $sampled(issue.inst2));
    a_full_holds: assert property (@(posedge clk) disable iff (fifo_rst)
        full && !read_en1 && !redirect_valid |=> full)
        else report_value("full", 1, $sampled(full));
    a_perf_master: assert property (@(posedge clk) disable iff (fifo_rst)
        perf.master_cnt == m_cnt)
        else report_value("perf.master_cnt", $sampled(m_cnt), $sampled(perf.master_cnt));
    a_perf_slave: assert property (@(posedge clk) disable iff (fifo_rst)
        perf.slave_cnt == s_cnt)
        else report_value("perf.slave_cnt", $sampled(s_cnt), $sampled(perf.slave_cnt));

    // each drive task steps to 1 ns past the next rising edge
    task idle_cycle(input logic rd1);
        @(posedge clk);
        #1;
        start          = 1'b0;
        load_req       = '0;
        read_en1       = rd1;
        read_en2       = 1'b0;
        redirect_valid = 1'b0;
        redir          = '0;
    endtask

    // branch is the current master and goes at the next edge
    task apply_redirect(input addr_t tgt, input logic keep);
        redirect_valid  = 1'b1;
        redir.target    = tgt;
        redir.keep_slot = keep;
        redir.slot_pc   = issue.addr1 + 32'd4;
        read_en1        = 1'b1;
        if (keep) read_en2 = 1'b0; // branch issued alone
    endtask

    task random_cycle;
        integer r;
        integer r2;
        r  = $random(seed);
        r2 = $random(seed);
        idle_cycle(r[0] | r[1]);
        read_en2 = read_en1 & r[2];
        if (r[6:3] == 4'd0) load_req = line_write(r2[9:0]); // same content steals the port
        if (!empty && !issue.in_delay_slot && !expect_slot
                && (r[11:7] == 5'd0 || issue.addr1 >= 32'h1000)) begin
            apply_redirect(addr_t'(r2[19:10]) << 2, r[12]);
        end
    endtask

    task wait_for(input string what, input int limit, input logic rd1);
        int n;
        n = 0;
        while ((what == "full" && !full) || (what == "data" && empty)
                || (what == "slot" && expect_slot)) begin
            idle_cycle(rd1);
            n++;
            if (n > limit) fail_now({"no ", what, " within the cycle limit"});
        end
    endtask

    initial begin
        int i;
        fifo_rst = 1'b1;
        start    = 1'b0;
        load_req = '0;
        read_en1 = 1'b0;
        read_en2 = 1'b0;
        redirect_valid = 1'b0;
        redir    = '0;
        keep_seen = 1'b0;
        buf_cnt  = 0;
        pend_cnt = 0;
        repeat (3) @(posedge clk);
        #1 fifo_rst = 1'b0;
        @(negedge clk);
        if (!empty) report_value("empty", 1, empty);
        if (full) report_value("full", 0, full);
        if (almost_empty) report_value("almost_empty", 0, almost_empty);
        if (perf != '0) report_value("perf", '0, perf);

        for (i = 0; i < LOAD_LINES; i++) begin
            idle_cycle(1'b0);
            load_req = line_write(i);
        end
        idle_cycle(1'b0);
        start = 1'b1;

        repeat (RANDOM_CYCLES) random_cycle();

        wait_for("slot", 100, 1'b1);
        idle_cycle(1'b0);
        wait_for("full", 80, 1'b0);     // stalled consumer
        repeat (8) idle_cycle(1'b0);
        apply_redirect(32'h0000_0100, 1'b1); // slot already buffered
        wait_for("slot", 100, 1'b1);

        idle_cycle(1'b0);
        apply_redirect(32'h0000_0204, 1'b0); // odd word target gets one entry
        idle_cycle(1'b0);
        wait_for("data", 40, 1'b0);
        apply_redirect(32'h0000_0300, 1'b1); // slot word not yet fetched
        wait_for("slot", 100, 1'b1);

        repeat (RANDOM_CYCLES) random_cycle();
        repeat (4) idle_cycle(1'b0);

        if (buf_cnt > 0 && pend_cnt > 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("keep_slot redirects missed a case, buffered %0d pending %0d",
                     buf_cnt, pend_cnt);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    end

    initial begin
        #(CYCLE_BUDGET * CLK_PERIOD * 2);
        $display("watchdog expired after %0d cycles", CYCLE_BUDGET * 2);
        $display("FAIL: see errors above");
        $fatal(1);
    end

endmodule

//--- sim.f
common/fetch_pkg.sv
common/mem_pkg.sv
inst_fifo/inst_fifo.sv
hdl/imem_arbiter.sv
hdl/inst_mem.sv
hdl/fetch_unit.sv
hdl/fetch_top.sv
verification/tb_fetch.sv

//--- run_sim.sh
#!/bin/sh
# build and run tb_fetch with Verilator, exit status follows the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fetch -f sim.f -o tb_fetch
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_fetch
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished cleanly"
exit 0
